//--- lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// ************************************************************
// LC-3b memory stage sizes
// ************************************************************

// Data and address width.
`define LC3B_WORD_W 16

// Register select and nzp field width.
`define LC3B_REG_W 3

// Trap vector is a word index, so it becomes a byte address.
`define LC3B_TRAP_SHIFT 1

`endif

//--- lc3b_pkg.sv
`include "lc3b_config.svh"

package lc3b_pkg;

    // ************************************************************
    // Vector types
    // ************************************************************

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [`LC3B_REG_W-1:0]  lc3b_reg;
    typedef logic [`LC3B_REG_W-1:0]  lc3b_nzp;     // {n, z, p}.

    // ************************************************************
    // Opcode and mux selects
    // ************************************************************

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // Memory address source.
    typedef enum logic [2:0] {
        marmux_alu    = 3'd0,
        marmux_pc     = 3'd1,
        marmux_br_add = 3'd2,
        marmux_rdata  = 3'd3,   // Indirect, LDI and STI.
        marmux_trap   = 3'd4
    } marmux_sel_t;

    // Store data source.
    typedef enum logic [2:0] {
        mdrmux_alu    = 3'd0,
        mdrmux_rdata  = 3'd1,
        mdrmux_sr1_hi = 3'd2,
        mdrmux_sr2    = 3'd3,
        mdrmux_stb    = 3'd4
    } mdrmux_sel_t;

    // Register write-back source.
    typedef enum logic [2:0] {
        regfilemux_alu    = 3'd0,
        regfilemux_rdata  = 3'd1,
        regfilemux_br_add = 3'd2,
        regfilemux_pc     = 3'd3,
        regfilemux_zext8  = 3'd4,
        regfilemux_shift  = 3'd5,
        regfilemux_ldb    = 3'd6
    } regfilemux_sel_t;

endpackage : lc3b_pkg

//--- mem_access.sv
`include "lc3b_config.svh"

module mem_access
    import lc3b_pkg::*;
(
    input  lc3b_opcode  opcode,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic [1:0]  mem_byte_enable,
    input  marmux_sel_t marmux_sel,
    input  mdrmux_sel_t mdrmux_sel,
    input  lc3b_word    alu_out,
    input  lc3b_word    pc_out,
    input  lc3b_word    br_add_out,
    input  lc3b_word    sr1_out,
    input  lc3b_word    sr2_out,
    input  lc3b_word    instruction,
    input  logic        resp_b,
    input  lc3b_word    rdata_b,
    output logic        read_b,
    output logic        write_b,
    output lc3b_word    address_b,
    output lc3b_word    wdata_b,
    output logic [1:0]  wmask_b,
    output logic        stall
);

    lc3b_word trap_vector;
    lc3b_word stb_data;
    logic     request;

    // ************************************************************
    // Address select
    // ************************************************************

    always_comb begin
        trap_vector = {{(`LC3B_WORD_W-8){1'b0}}, instruction[7:0]};
        trap_vector = trap_vector << `LC3B_TRAP_SHIFT;
    end

    always_comb begin
        unique case (marmux_sel)
            marmux_alu:    address_b = alu_out;
            marmux_pc:     address_b = pc_out;
            marmux_br_add: address_b = br_add_out;
            marmux_rdata:  address_b = rdata_b;
            marmux_trap:   address_b = trap_vector;
            default:       address_b = '0;
        endcase
    end

    // ************************************************************
    // Store data and byte lanes
    // ************************************************************

    always_comb begin
        if (address_b[0]) begin
            stb_data = {sr2_out[7:0], 8'h00};  // High lane.
        end else begin
            stb_data = {8'h00, sr2_out[7:0]};  // Low lane.
        end
    end

    always_comb begin
        unique case (mdrmux_sel)
            mdrmux_alu:    wdata_b = alu_out;
            mdrmux_rdata:  wdata_b = rdata_b;
            mdrmux_sr1_hi: wdata_b = sr1_out << 8;
            mdrmux_sr2:    wdata_b = sr2_out;
            mdrmux_stb:    wdata_b = stb_data;
            default:       wdata_b = '0;
        endcase
    end

    always_comb begin
        if (opcode == op_stb) begin
            wmask_b = address_b[0] ? 2'b10 : 2'b01;
        end else begin
            wmask_b = mem_byte_enable;
        end
    end

    // ************************************************************
    // Request and stall
    // ************************************************************

    // Level request, held by the pipeline until resp_b.
    assign read_b  = mem_read;
    assign write_b = mem_write;
    assign request = mem_read | mem_write;
    assign stall   = request & ~resp_b;

endmodule : mem_access

//--- load_format.sv
`include "lc3b_config.svh"

module load_format
    import lc3b_pkg::*;
(
    input  regfilemux_sel_t regfilemux_sel,
    input  lc3b_word        alu_out,
    input  lc3b_word        pc_out,
    input  lc3b_word        br_add_out,
    input  lc3b_word        sr1_out,
    input  lc3b_word        instruction,
    input  lc3b_word        rdata_b,
    input  logic            byte_sel,
    output lc3b_word        regfilemux_out
);

    logic [7:0] ldb_byte;
    lc3b_word   ldb_zext;
    lc3b_word   zext8;
    lc3b_word   shift_out;
    logic [3:0] shift_amt;
    logic       shift_right;
    logic       shift_arith;

    // ************************************************************
    // Load byte
    // ************************************************************

    always_comb begin
        if (byte_sel) begin
            ldb_byte = rdata_b[15:8];  // Odd address.
        end else begin
            ldb_byte = rdata_b[7:0];
        end
    end

    assign ldb_zext = {{(`LC3B_WORD_W-8){1'b0}}, ldb_byte};

    // Low byte regardless of address.
    assign zext8 = {{(`LC3B_WORD_W-8){1'b0}}, rdata_b[7:0]};

    // ************************************************************
    // Shift unit
    // ************************************************************

    // SHF: bit 4 picks direction, bit 5 makes a right shift arithmetic.
    assign shift_amt   = instruction[3:0];
    assign shift_right = instruction[4];
    assign shift_arith = instruction[5];

    always_comb begin
        if (!shift_right) begin
            shift_out = sr1_out << shift_amt;
        end else if (shift_arith) begin
            shift_out = $signed(sr1_out) >>> shift_amt;  // Sign fill.
        end else begin
            shift_out = sr1_out >> shift_amt;
        end
    end

    // ************************************************************
    // Write-back select
    // ************************************************************

    always_comb begin
        unique case (regfilemux_sel)
            regfilemux_alu: begin
                regfilemux_out = alu_out;
            end
            regfilemux_rdata: begin
                regfilemux_out = rdata_b;    // LDW.
            end
            regfilemux_br_add: begin
                regfilemux_out = br_add_out;  // LEA.
            end
            regfilemux_pc: begin
                regfilemux_out = pc_out;      // Link for JSR and TRAP.
            end
            regfilemux_zext8: begin
                regfilemux_out = zext8;
            end
            regfilemux_shift: begin
                regfilemux_out = shift_out;
            end
            regfilemux_ldb: begin
                regfilemux_out = ldb_zext;
            end
            default: begin
                regfilemux_out = '0;
            end
        endcase
    end

endmodule : load_format

//--- cond_codes.sv
`include "lc3b_config.svh"

module cond_codes
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  lc3b_opcode opcode,
    input  logic       load_cc,
    input  logic       stall,
    input  lc3b_word   regfilemux_out,
    input  lc3b_word   instruction,
    input  lc3b_word   rdata_b,
    input  lc3b_reg    dest,
    input  logic       resp_b,
    output logic       br_en,
    output logic       jmp_jsr_en,
    output logic       b11,
    output logic       trap_en,
    output lc3b_word   trap_mem
);

    lc3b_nzp gencc;
    lc3b_nzp cc;

    // ************************************************************
    // Condition codes
    // ************************************************************

    always_comb begin
        if (regfilemux_out[`LC3B_WORD_W-1]) begin
            gencc = 3'b100;
        end else if (regfilemux_out == '0) begin
            gencc = 3'b010;
        end else begin
            gencc = 3'b001;
        end
    end

    // Holds during a stall so a waiting load does not set codes early.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc <= 3'b010;
        end else if (load_cc && !stall) begin
            cc <= gencc;
        end
    end

    // ************************************************************
    // Redirects
    // ************************************************************

    // dest carries the nzp field for BR.
    assign br_en      = (opcode == op_br) && ((cc & dest) != '0);
    assign jmp_jsr_en = (opcode == op_jmp) || (opcode == op_jsr);
    assign b11        = instruction[11];  // JSR versus JSRR.

    always_comb begin
        if (opcode == op_trap && resp_b) begin
            trap_en  = 1'b1;
            trap_mem = rdata_b;  // Service routine address.
        end else begin
            trap_en  = 1'b0;
            trap_mem = '0;
        end
    end

endmodule : cond_codes

//--- mem_stage.sv
module mem_stage
    import lc3b_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    // Pipeline control.
    input  lc3b_opcode      opcode,
    input  logic            mem_read,
    input  logic            mem_write,
    input  logic [1:0]      mem_byte_enable,
    input  marmux_sel_t     marmux_sel,
    input  mdrmux_sel_t     mdrmux_sel,
    input  regfilemux_sel_t regfilemux_sel,
    input  logic            load_cc,

    // Pipeline operands.
    input  lc3b_word        alu_out,
    input  lc3b_word        pc_out,
    input  lc3b_word        br_add_out,
    input  lc3b_word        sr1_out,
    input  lc3b_word        sr2_out,
    input  lc3b_word        instruction,
    input  lc3b_reg         dest,

    // Memory port.
    input  logic            resp_b,
    input  lc3b_word        rdata_b,
    output logic            read_b,
    output logic            write_b,
    output lc3b_word        address_b,
    output lc3b_word        wdata_b,
    output logic [1:0]      wmask_b,

    // To write-back and fetch.
    output lc3b_word        regfilemux_out,
    output logic            stall,
    output logic            br_en,
    output logic            jmp_jsr_en,
    output logic            b11,
    output logic            trap_en,
    output lc3b_word        trap_mem
);

    mem_access mem_access_i (
        .opcode          (opcode),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .marmux_sel      (marmux_sel),
        .mdrmux_sel      (mdrmux_sel),
        .alu_out         (alu_out),
        .pc_out          (pc_out),
        .br_add_out      (br_add_out),
        .sr1_out         (sr1_out),
        .sr2_out         (sr2_out),
        .instruction     (instruction),
        .resp_b          (resp_b),
        .rdata_b         (rdata_b),
        .read_b          (read_b),
        .write_b         (write_b),
        .address_b       (address_b),
        .wdata_b         (wdata_b),
        .wmask_b         (wmask_b),
        .stall           (stall)
    );

    load_format load_format_i (
        .regfilemux_sel (regfilemux_sel),
        .alu_out        (alu_out),
        .pc_out         (pc_out),
        .br_add_out     (br_add_out),
        .sr1_out        (sr1_out),
        .instruction    (instruction),
        .rdata_b        (rdata_b),
        .byte_sel       (address_b[0]),  // Load byte lane.
        .regfilemux_out (regfilemux_out)
    );

    cond_codes cond_codes_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .opcode         (opcode),
        .load_cc        (load_cc),
        .stall          (stall),
        .regfilemux_out (regfilemux_out),
        .instruction    (instruction),
        .rdata_b        (rdata_b),
        .dest           (dest),
        .resp_b         (resp_b),
        .br_en          (br_en),
        .jmp_jsr_en     (jmp_jsr_en),
        .b11            (b11),
        .trap_en        (trap_en),
        .trap_mem       (trap_mem)
    );

endmodule : mem_stage

//--- mem_stage_chk.sv
module mem_stage_chk
    import lc3b_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input lc3b_opcode opcode,
    input logic       read_b,
    input logic       write_b,
    input logic       resp_b,
    input logic [1:0] wmask_b,
    input logic       stall,
    input logic       trap_en
);

    // ************************************************************
    // Memory port rules
    // ************************************************************

    a_stall_req: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> (read_b || write_b) && !resp_b)
        else $error("stall without a pending request");

    a_stb_lane: assert property (@(posedge clk) disable iff (!rst_n)
        (opcode == op_stb) |-> (wmask_b == 2'b01 || wmask_b == 2'b10))
        else $error("STB mask is not a single lane");

    a_trap_resp: assert property (@(posedge clk) disable iff (!rst_n)
        trap_en |-> resp_b)
        else $error("trap_en without resp_b");

    a_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_b && write_b))
        else $error("read_b and write_b high together");

endmodule : mem_stage_chk

bind mem_stage mem_stage_chk mem_stage_chk_i (.*);

//--- mem_stage_tb.sv
`include "lc3b_config.svh"

module mem_stage_tb
    import lc3b_pkg::*;
();

    typedef struct {
        lc3b_opcode      op;
        logic            rd;
        logic            wr;
        logic [1:0]      be;
        marmux_sel_t     mar;
        mdrmux_sel_t     mdr;
        regfilemux_sel_t rfm;
        logic            lcc;
        lc3b_word        alu;
        lc3b_word        sr1;
        lc3b_word        sr2;
        lc3b_word        ins;
        lc3b_reg         dst;
        logic            resp;
        lc3b_word        rdata;
        logic            rnd;      // Operands come from the LFSR.
        lc3b_word        e_addr;
        lc3b_word        e_wdata;
        logic [1:0]      e_wmask;
        lc3b_word        e_rf;
        logic            e_br;
    } row_t;

    logic            clk;
    logic            rst_n;
    lc3b_opcode      opcode;
    logic            mem_read;
    logic            mem_write;
    logic [1:0]      mem_byte_enable;
    marmux_sel_t     marmux_sel;
    mdrmux_sel_t     mdrmux_sel;
    regfilemux_sel_t regfilemux_sel;
    logic            load_cc;
    lc3b_word        alu_out;
    lc3b_word        pc_out;
    lc3b_word        br_add_out;
    lc3b_word        sr1_out;
    lc3b_word        sr2_out;
    lc3b_word        instruction;
    lc3b_reg         dest;
    logic            resp_b;
    lc3b_word        rdata_b;
    logic            read_b;
    logic            write_b;
    lc3b_word        address_b;
    lc3b_word        wdata_b;
    logic [1:0]      wmask_b;
    lc3b_word        regfilemux_out;
    logic            stall;
    logic            br_en;
    logic            jmp_jsr_en;
    logic            b11;
    logic            trap_en;
    lc3b_word        trap_mem;

    row_t        rows[$];
    row_t        r;
    lc3b_word    rnd_amt;
    logic [31:0] lfsr = 32'hc478;
    int          errors = 0;
    int          checks = 0;

    mem_stage mem_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ************************************************************
    // Helpers
    // ************************************************************

    function automatic lc3b_word rand_bits(int n);
        lc3b_word val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
            val  = {val[14:0], lfsr[0]};
        end
        return val;
    endfunction

    // SHF reference, one bit position per step.
    function automatic lc3b_word shift_ref(lc3b_word a, lc3b_word ins);
        lc3b_word res;
        res = a;
        for (int i = 0; i < ins[3:0]; i++) begin
            if (!ins[4]) res = {res[14:0], 1'b0};
            else if (ins[5]) res = {res[15], res[15:1]};
            else res = {1'b0, res[15:1]};
        end
        return res;
    endfunction

    task automatic check(string name, lc3b_word got, lc3b_word exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(lc3b_opcode op, logic rd, logic wr, logic [1:0] be,
                           marmux_sel_t mar, mdrmux_sel_t mdr, regfilemux_sel_t rfm,
                           logic lcc, lc3b_word alu, lc3b_word sr1, lc3b_word sr2,
                           lc3b_word ins, lc3b_reg dst, logic resp, lc3b_word rdata,
                           logic rnd, lc3b_word e_addr, lc3b_word e_wdata,
                           logic [1:0] e_wmask, lc3b_word e_rf, logic e_br);
        row_t t;
        t = '{op, rd, wr, be, mar, mdr, rfm, lcc, alu, sr1, sr2, ins, dst, resp, rdata,
              rnd, e_addr, e_wdata, e_wmask, e_rf, e_br};
        rows.push_back(t);
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (stall !== 1'b0 && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        if (stall !== 1'b0) begin
            errors++;
            $display("stall did not go low after reset within 20 cycles");
        end
    endtask

    // ************************************************************
    // Stimulus table
    // ************************************************************

    initial begin
        // pc_out is 3000 and br_add_out is 3456 in every row.
        add_row(op_br, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'h0000, 3'b010, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 1);
        add_row(op_br, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'h0000, 3'b101, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 0);
        add_row(op_ldr, 1, 0, 2'b11, marmux_pc, mdrmux_alu, regfilemux_rdata, 1, 16'h1234,
                0, 0, 16'h6000, 3'b000, 0, 16'h8000, 0, 16'h3000, 16'h1234, 2'b11, 16'h8000, 0);
        add_row(op_ldr, 1, 0, 2'b11, marmux_pc, mdrmux_alu, regfilemux_rdata, 1, 16'h1234,
                0, 0, 16'h6000, 3'b000, 0, 16'h8000, 0, 16'h3000, 16'h1234, 2'b11, 16'h8000, 0);
        add_row(op_br, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'h0000, 3'b010, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 1);
        add_row(op_ldr, 1, 0, 2'b11, marmux_pc, mdrmux_alu, regfilemux_rdata, 1, 16'h1234,
                0, 0, 16'h6000, 3'b000, 1, 16'h8000, 0, 16'h3000, 16'h1234, 2'b11, 16'h8000, 0);
        add_row(op_br, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'h0000, 3'b100, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 1);
        add_row(op_br, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'h0000, 3'b011, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 0);
        add_row(op_add, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 1, 16'h0000,
                0, 0, 16'h1000, 3'b100, 0, 0, 0, 16'h0000, 16'h0000, 2'b00, 16'h0000, 0);
        add_row(op_br, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'h0000, 3'b010, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 1);
        add_row(op_add, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 1, 16'h1234,
                0, 0, 16'h1000, 3'b000, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 0);
        add_row(op_br, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'h0000, 3'b001, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 1);
        add_row(op_br, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'h0000, 3'b110, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 0);
        add_row(op_stb, 0, 1, 2'b00, marmux_alu, mdrmux_stb, regfilemux_alu, 0, 16'h1234,
                0, 16'h77ab, 16'h3000, 3'b000, 1, 0, 0, 16'h1234, 16'h00ab, 2'b01, 16'h1234, 0);
        add_row(op_stb, 0, 1, 2'b00, marmux_alu, mdrmux_stb, regfilemux_alu, 0, 16'h1235,
                0, 16'h77ab, 16'h3000, 3'b000, 1, 0, 0, 16'h1235, 16'hab00, 2'b10, 16'h1235, 0);
        add_row(op_stb, 0, 1, 2'b00, marmux_br_add, mdrmux_stb, regfilemux_alu, 0, 16'h1235,
                0, 16'h77ab, 16'h3000, 3'b000, 1, 0, 0, 16'h3456, 16'h00ab, 2'b01, 16'h1235, 0);
        add_row(op_str, 0, 1, 2'b11, marmux_pc, mdrmux_sr2, regfilemux_alu, 0, 16'h1234,
                0, 16'hbeef, 16'h7000, 3'b000, 1, 0, 0, 16'h3000, 16'hbeef, 2'b11, 16'h1234, 0);
        add_row(op_sti, 0, 1, 2'b11, marmux_rdata, mdrmux_sr1_hi, regfilemux_alu, 0, 16'h1234,
                16'h0012, 0, 16'hb000, 3'b000, 1, 16'h4000, 0, 16'h4000, 16'h1200, 2'b11,
                16'h1234, 0);
        add_row(op_ldb, 1, 0, 2'b00, marmux_alu, mdrmux_rdata, regfilemux_ldb, 0, 16'h1235,
                0, 0, 16'h2000, 3'b000, 1, 16'ha5c3, 0, 16'h1235, 16'ha5c3, 2'b00, 16'h00a5, 0);
        add_row(op_ldb, 1, 0, 2'b00, marmux_alu, mdrmux_rdata, regfilemux_ldb, 0, 16'h1234,
                0, 0, 16'h2000, 3'b000, 1, 16'ha5c3, 0, 16'h1234, 16'ha5c3, 2'b00, 16'h00c3, 0);
        add_row(op_trap, 1, 0, 2'b11, marmux_trap, mdrmux_alu, regfilemux_pc, 0, 16'h1234,
                0, 0, 16'hf025, 3'b000, 0, 16'h1000, 0, 16'h004a, 16'h1234, 2'b11, 16'h3000, 0);
        add_row(op_trap, 1, 0, 2'b11, marmux_trap, mdrmux_alu, regfilemux_pc, 0, 16'h1234,
                0, 0, 16'hf025, 3'b000, 1, 16'h1000, 0, 16'h004a, 16'h1234, 2'b11, 16'h3000, 0);
        add_row(op_jsr, 0, 0, 2'b00, marmux_pc, mdrmux_alu, regfilemux_pc, 0, 16'h1234,
                0, 0, 16'h4800, 3'b000, 0, 0, 0, 16'h3000, 16'h1234, 2'b00, 16'h3000, 0);
        add_row(op_jmp, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_alu, 0, 16'h1234,
                0, 0, 16'hc1c0, 3'b000, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h1234, 0);
        add_row(op_lea, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_br_add, 0, 16'h1234,
                0, 0, 16'he000, 3'b000, 0, 0, 0, 16'h1234, 16'h1234, 2'b00, 16'h3456, 0);
        add_row(op_add, 0, 0, 2'b00, marmux_alu, mdrmux_alu, regfilemux_zext8, 0, 16'h1235,
                0, 0, 16'h1000, 3'b000, 0, 16'h12f7, 0, 16'h1235, 16'h1235, 2'b00, 16'h00f7, 0);
        // Left, logical right and arithmetic right shifts with random operands.
        add_row(op_shf, 0, 0, 2'b00, marmux_alu, mdrmux_sr2, regfilemux_shift, 0, 16'h1234,
                0, 0, 16'hd000, 3'b000, 0, 0, 1, 16'h1234, 0, 2'b00, 0, 0);
        add_row(op_shf, 0, 0, 2'b00, marmux_alu, mdrmux_sr2, regfilemux_shift, 0, 16'h1234,
                0, 0, 16'hd010, 3'b000, 0, 0, 1, 16'h1234, 0, 2'b00, 0, 0);
        add_row(op_shf, 0, 0, 2'b00, marmux_alu, mdrmux_sr2, regfilemux_shift, 0, 16'h1234,
                0, 0, 16'hd030, 3'b000, 0, 0, 1, 16'h1234, 0, 2'b00, 0, 0);
        // Arithmetic right shift of a negative operand.
        add_row(op_shf, 0, 0, 2'b00, marmux_alu, mdrmux_sr2, regfilemux_shift, 0, 16'h1234,
                16'h8421, 0, 16'hd034, 3'b000, 0, 0, 0, 16'h1234, 16'h0000, 2'b00, 16'hf842, 0);
    end

    // ************************************************************
    // Run
    // ************************************************************

    initial begin
        rst_n = 1'b0;
        opcode = op_br;
        {mem_read, mem_write, load_cc, resp_b} = '0;
        mem_byte_enable = 2'b00;
        marmux_sel = marmux_alu;
        mdrmux_sel = mdrmux_alu;
        regfilemux_sel = regfilemux_alu;
        {alu_out, sr1_out, sr2_out, instruction, rdata_b} = '0;
        pc_out = 16'h3000;
        br_add_out = 16'h3456;
        dest = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        wait_idle();
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.rnd) begin
                r.sr1 = rand_bits(16);
                r.sr2 = rand_bits(16);
                r.rdata = rand_bits(16);
                rnd_amt = rand_bits(4);
                r.ins[3:0] = rnd_amt[3:0];
                r.e_wdata = r.sr2;
                r.e_rf = shift_ref(r.sr1, r.ins);
            end
            @(negedge clk);
            opcode = r.op;
            mem_read = r.rd;
            mem_write = r.wr;
            mem_byte_enable = r.be;
            marmux_sel = r.mar;
            mdrmux_sel = r.mdr;
            regfilemux_sel = r.rfm;
            load_cc = r.lcc;
            alu_out = r.alu;
            sr1_out = r.sr1;
            sr2_out = r.sr2;
            instruction = r.ins;
            dest = r.dst;
            resp_b = r.resp;
            rdata_b = r.rdata;
            #3;  // Just before the rising edge.
            check("address_b", address_b, r.e_addr);
            check("wdata_b", wdata_b, r.e_wdata);
            check("wmask_b", wmask_b, r.e_wmask);
            check("regfilemux_out", regfilemux_out, r.e_rf);
            check("br_en", br_en, r.e_br);
            check("read_b", read_b, r.rd);
            check("write_b", write_b, r.wr);
            check("stall", stall, (r.rd | r.wr) & ~r.resp);
            check("jmp_jsr_en", jmp_jsr_en, r.op == op_jmp || r.op == op_jsr);
            check("b11", b11, r.ins[11]);
            check("trap_en", trap_en, r.op == op_trap && r.resp);
            check("trap_mem", trap_mem, (r.op == op_trap && r.resp) ? r.rdata : 16'h0000);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : mem_stage_tb

//--- mem_stage.f
+incdir+.
lc3b_pkg.sv
mem_access.sv
load_format.sv
cond_codes.sv
mem_stage.sv
mem_stage_chk.sv
mem_stage_tb.sv

//--- Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lc3b_pkg.sv
      - mem_access.sv
      - load_format.sv
      - cond_codes.sv
      - mem_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - mem_stage_chk.sv
      - mem_stage_tb.sv
